// ==== rtl/repl_pkg.sv ====
// Replacement geometry and types shared by the age table, the comparator tree and the testbench

package repl_pkg;

    // ------------------------------
    // Geometry
    // ------------------------------
    localparam int NUM_WAYS = 8;
    localparam int NUM_SETS = 8;

    // Upper bound on ways that the tree and the mask support
    localparam int MAX_WAYS = 16;

    localparam int AGE_W = 4;
    localparam int WAY_W = 4;
    localparam int SET_W = 3;

    // ------------------------------
    // Scalar types
    // ------------------------------
    typedef logic [AGE_W-1:0]    age_t;
    typedef logic [WAY_W-1:0]    way_idx_t;
    typedef logic [SET_W-1:0]    set_idx_t;
    typedef logic [MAX_WAYS-1:0] way_mask_t;

    // Ages stop counting here
    localparam age_t AGE_MAX = '1;

    // ------------------------------
    // Structs
    // ------------------------------
    // Clears the age of one way and ages its neighbours in the same set
    typedef struct packed {
        logic     valid;
        set_idx_t set;
        way_idx_t way;
    } touch_req_t;

    // Oldest unlocked way of a set, found low when every way is locked
    typedef struct packed {
        logic     found;
        way_idx_t way;
        age_t     age;
    } victim_t;

endpackage

// ==== rtl/axil_pkg.sv ====
// AXI4-Lite channel types, register map and response codes for the victim selector register slave

package axil_pkg;

    typedef logic [7:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // ------------------------------
    // Register map
    // ------------------------------
    // Write only, set in bits 2:0, way in bits 7:4
    localparam addr_t REG_TOUCH  = 8'h00;
    // Lock mask in bits 15:0
    localparam addr_t REG_LOCK   = 8'h04;
    // Set used for the victim query, bits 2:0
    localparam addr_t REG_QSET   = 8'h08;
    // Read only: found in bit 31, way in bits 7:4, age in bits 3:0
    localparam addr_t REG_VICTIM = 8'h0C;

    // ------------------------------
    // Channel bundles
    // ------------------------------
    typedef struct packed {
        logic  awvalid;
        addr_t awaddr;
        logic  wvalid;
        data_t wdata;
        logic  bready;
        logic  arvalid;
        addr_t araddr;
        logic  rready;
    } axil_req_t;

    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } axil_rsp_t;

endpackage

// ==== rtl/max_age_tree.sv ====
// Combinational masked comparator tree returning the oldest candidate way; used by the top level
`timescale 1ns/100ps

module max_age_tree #(
    parameter int NUM_WAY = repl_pkg::NUM_WAYS
) (
    input  repl_pkg::age_t [NUM_WAY-1:0] ages,
    input  repl_pkg::way_mask_t          candidates,
    output repl_pkg::victim_t            victim
);
    import repl_pkg::*;

    // One comparator layer per halving, NUM_WAY must be a power of two up to 16
    localparam int LAYERS = $clog2(NUM_WAY);

    // Right node wins only with a strictly larger age, so ties stay with the lower index.
    // A node without a candidate never beats one with a candidate
    function automatic victim_t pick(victim_t left, victim_t right);
        victim_t win;
        win = left;
        if (right.found && (!left.found || right.age > left.age))
        begin
            win = right;
        end
        return win;
    endfunction

    // ------------------------------
    // Layers, 0 holds the leaves
    // ------------------------------
    for (genvar d = 0; d <= LAYERS; d++)
    begin : g_layer
        victim_t [(NUM_WAY >> d)-1:0] lvl;

        if (d == 0)
        begin : g_leaf
            // Masked ways enter with age 0 and found low
            for (genvar i = 0; i < NUM_WAY; i++)
            begin : g_way
                assign lvl[i] = '{
                    found: candidates[i],
                    way:   way_idx_t'(i),
                    age:   candidates[i] ? ages[i] : '0
                };
            end
        end
        else
        begin : g_cmp
            // Adjacent pairs of the layer below
            for (genvar j = 0; j < (NUM_WAY >> d); j++)
            begin : g_node
                assign lvl[j] = pick(g_layer[d-1].lvl[2*j], g_layer[d-1].lvl[2*j+1]);
            end
        end
    end

    assign victim = g_layer[LAYERS].lvl[0];

endmodule

// ==== rtl/age_table.sv ====
// Per-set, per-way saturating age counters updated by touch requests; read out for one query set
`timescale 1ns/100ps

module age_table #(
    parameter int NUM_WAY = repl_pkg::NUM_WAYS
) (
    input  logic                         clk,
    input  logic                         rst,
    input  repl_pkg::touch_req_t         touch,
    input  repl_pkg::set_idx_t           query_set,
    output repl_pkg::age_t [NUM_WAY-1:0] ages
);
    import repl_pkg::*;

    age_t [NUM_WAY-1:0] age_q [NUM_SETS];

    // ------------------------------
    // Update
    // ------------------------------
    // Touched way restarts at 0, the rest of the set gets one older
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                age_q[s] <= '0;
            end
        end
        else if (touch.valid)
        begin
            for (int w = 0; w < NUM_WAY; w++)
            begin
                if (way_idx_t'(w) == touch.way)
                begin
                    age_q[touch.set][w] <= '0;
                end
                else if (age_q[touch.set][w] != AGE_MAX)
                begin
                    age_q[touch.set][w] <= age_q[touch.set][w] + age_t'(1);
                end
            end
        end
    end

    // ------------------------------
    // Read
    // ------------------------------
    // No register stage, the tree sees the set in the same cycle
    assign ages = age_q[query_set];

endmodule

// ==== rtl/repl_axil_regs.sv ====
// AXI4-Lite register slave for lock mask, query set, touches and the victim result; used by the top
`timescale 1ns/100ps

module repl_axil_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  axil_pkg::axil_req_t  axil_req,
    output axil_pkg::axil_rsp_t  axil_rsp,
    input  repl_pkg::victim_t    victim,
    output repl_pkg::touch_req_t touch,
    output repl_pkg::way_mask_t  candidates,
    output repl_pkg::set_idx_t   query_set
);
    import axil_pkg::*;
    import repl_pkg::*;

    logic      wr_accept;
    logic      rd_accept;
    logic      bvalid_q;
    logic      rvalid_q;
    data_t     rdata_q;
    data_t     rd_mux;
    way_mask_t lock_q;
    set_idx_t  qset_q;
    logic      touch_valid_q;
    set_idx_t  touch_set_q;
    way_idx_t  touch_way_q;

    // Address and data are taken together, one write in flight at a time
    assign wr_accept = axil_req.awvalid && axil_req.wvalid && !bvalid_q;
    assign rd_accept = axil_req.arvalid && !rvalid_q;

    // ------------------------------
    // Write channel
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bvalid_q      <= 1'b0;
            touch_valid_q <= 1'b0;
            lock_q        <= '0;
            qset_q        <= '0;
        end
        else
        begin
            // Touch is a single-cycle pulse
            touch_valid_q <= 1'b0;
            if (wr_accept)
            begin
                bvalid_q <= 1'b1;
                case (axil_req.awaddr)
                    REG_TOUCH: touch_valid_q <= 1'b1;
                    REG_LOCK:  lock_q        <= axil_req.wdata[15:0];
                    REG_QSET:  qset_q        <= axil_req.wdata[2:0];
                    // Victim and unknown offsets only get a response
                    default:   ;
                endcase
            end
            else if (axil_req.bready)
            begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            touch_set_q <= axil_req.wdata[2:0];
            touch_way_q <= axil_req.wdata[7:4];
        end
    end

    // ------------------------------
    // Read channel
    // ------------------------------
    always_comb
    begin
        case (axil_req.araddr)
            REG_LOCK:   rd_mux = data_t'(lock_q);
            REG_QSET:   rd_mux = data_t'(qset_q);
            REG_VICTIM: rd_mux = {victim.found, 23'd0, victim.way, victim.age};
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rvalid_q <= 1'b0;
        end
        else if (rd_accept)
        begin
            rvalid_q <= 1'b1;
        end
        else if (axil_req.rready)
        begin
            rvalid_q <= 1'b0;
        end
    end

    // Data is frozen at acceptance and held while rvalid waits
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            rdata_q <= rd_mux;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign touch = '{
        valid: touch_valid_q,
        set:   touch_set_q,
        way:   touch_way_q
    };

    // Locked ways drop out of the victim search
    assign candidates = ~lock_q;
    assign query_set  = qset_q;

    assign axil_rsp = '{
        awready: wr_accept,
        wready:  wr_accept,
        bvalid:  bvalid_q,
        bresp:   RESP_OKAY,
        arready: !rvalid_q,
        rvalid:  rvalid_q,
        rdata:   rdata_q,
        rresp:   RESP_OKAY
    };

endmodule

// ==== rtl/victim_select_top.sv ====
// Top level of the cache victim selector, exposing clock, reset and one AXI4-Lite slave port
`timescale 1ns/100ps

module victim_select_top #(
    parameter int NUM_WAY = repl_pkg::NUM_WAYS
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp
);
    import repl_pkg::*;

    touch_req_t           touch;
    set_idx_t             query_set;
    way_mask_t            candidates;
    age_t [NUM_WAY-1:0]   ages;
    victim_t              victim;

    repl_axil_regs i_repl_axil_regs (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .victim     (victim),
        .touch      (touch),
        .candidates (candidates),
        .query_set  (query_set)
    );

    age_table #(
        .NUM_WAY (NUM_WAY)
    ) i_age_table (
        .clk       (clk),
        .rst       (rst),
        .touch     (touch),
        .query_set (query_set),
        .ages      (ages)
    );

    max_age_tree #(
        .NUM_WAY (NUM_WAY)
    ) i_max_age_tree (
        .ages       (ages),
        .candidates (candidates),
        .victim     (victim)
    );

endmodule

// ==== verification/victim_select_properties.sv ====
// Concurrent checks on the register slave's AXI4-Lite handshakes and victim legality, bound in
`timescale 1ns/100ps

module victim_select_properties (
    input logic                clk,
    input logic                rst,
    input axil_pkg::axil_req_t axil_req,
    input axil_pkg::axil_rsp_t axil_rsp,
    input repl_pkg::victim_t   victim,
    input repl_pkg::way_mask_t candidates
);
    import axil_pkg::*;

    // Both response channels come out of reset idle
    reset_idle: assert property (@(posedge clk)
        rst |=> !axil_rsp.bvalid && !axil_rsp.rvalid)
        else $error("bvalid or rvalid high in the cycle after reset");

    // ------------------------------
    // Response hold
    // ------------------------------
    b_held: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && axil_rsp.bresp == RESP_OKAY)
        else $error("bvalid dropped or bresp changed before bready");

    r_held: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid dropped or rdata changed before rready");

    // A write offered while the response is pending must not reach the lock mask
    no_write_while_b: assert property (@(posedge clk) disable iff (rst)
        axil_rsp.bvalid |=> $stable(candidates))
        else $error("write accepted while a write response was pending");

    // ------------------------------
    // Victim
    // ------------------------------
    victim_unlocked: assert property (@(posedge clk) disable iff (rst)
        victim.found |-> candidates[victim.way])
        else $error("victim way is a locked way");

endmodule

bind repl_axil_regs victim_select_properties i_victim_select_properties (
    .clk        (clk),
    .rst        (rst),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .victim     (victim),
    .candidates (candidates)
);

// ==== verification/tb_victim_select.sv ====
// Testbench for the victim selector; drives AXI4-Lite traffic and checks reads against an age model
`timescale 1ns/100ps

module tb_victim_select;
    import repl_pkg::*;
    import axil_pkg::*;

    localparam int NUM_WAY = 8;
    localparam int N_TOUCH = 300;
    localparam int N_LOCK  = 100;
    // Upper bound on the AXI operations of the whole run
    localparam int NUM_OPS        = 100 + 3 * N_TOUCH + 5 * N_LOCK;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 20 + 200;

    logic        clk = 1'b0;
    logic        rst;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [31:0] rng_state = 32'h835dd1cb;
    logic        run_ended = 1'b0;
    int          model_age [NUM_SETS][NUM_WAY];
    logic [15:0] model_lock;

    victim_select_top #(
        .NUM_WAY (NUM_WAY)
    ) i_victim_select_top (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic void model_touch(set_idx_t set, way_idx_t way);
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (w == way)
                model_age[set][w] = 0;
            else if (model_age[set][w] < 15)
                model_age[set][w]++;
        end
    endfunction

    // Only a strictly older way replaces the best so far, so ties keep the lower index
    function automatic data_t model_victim(set_idx_t set);
        int best_way;
        int best_age;
        best_way = -1;
        best_age = -1;
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (!model_lock[w] && model_age[set][w] > best_age)
            begin
                best_way = w;
                best_age = model_age[set][w];
            end
        end
        if (best_way < 0)
            return 32'h0;
        return {1'b1, 23'd0, 4'(best_way), 4'(best_age)};
    endfunction

    // ------------------------------
    // AXI4-Lite driver
    // ------------------------------
    task automatic report_mismatch(string name, data_t expected, data_t actual);
        run_ended = 1'b1;
        $display("Mismatch at %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
        $display("Test failed");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    // Address and data stay offered while the response waits, so a second accept would show
    task automatic axi_write(addr_t addr, data_t data);
        int hold;
        hold = int'(rand32() % 4);
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        // bvalid shows up right after the edge that took address and data
        do
        begin
            @(negedge clk);
        end
        while (!axil_rsp.bvalid);
        assert (axil_rsp.bresp == RESP_OKAY)
        else
            report_mismatch("bresp", data_t'(RESP_OKAY), data_t'(axil_rsp.bresp));
        repeat (hold) @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axi_read(addr_t addr, output data_t data);
        int hold;
        hold = int'(rand32() % 4);
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        do
        begin
            @(negedge clk);
        end
        while (!axil_rsp.rvalid);
        axil_req.arvalid = 1'b0;
        repeat (hold) @(negedge clk);
        data = axil_rsp.rdata;
        assert (axil_rsp.rresp == RESP_OKAY)
        else
            report_mismatch("rresp", data_t'(RESP_OKAY), data_t'(axil_rsp.rresp));
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic check_read(addr_t addr, data_t expected, data_t mask, string name);
        data_t got;
        axi_read(addr, got);
        assert ((got & mask) == (expected & mask))
        else
            report_mismatch(name, expected & mask, got & mask);
    endtask

    task automatic touch_way(set_idx_t set, way_idx_t way);
        axi_write(REG_TOUCH, {24'd0, way, 1'b0, set});
        model_touch(set, way);
    endtask

    task automatic write_lock(data_t value);
        axi_write(REG_LOCK, value);
        model_lock = value[15:0];
    endtask

    // Without a victim only the found bit is defined
    task automatic query_victim(set_idx_t set);
        data_t expected;
        axi_write(REG_QSET, data_t'(set));
        expected = model_victim(set);
        check_read(REG_VICTIM, expected, expected[31] ? 32'hffff_ffff : 32'h8000_0000,
                   "rdata of REG_VICTIM");
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic run_stimulus();
        data_t    value;
        set_idx_t set;
        way_idx_t way;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        for (int s = 0; s < NUM_SETS; s++)
            query_victim(set_idx_t'(s));
        check_read(REG_LOCK, 32'h0, '1, "rdata of REG_LOCK");

        // Way 0 of set 5 stays young while the rest saturate, then lock off from the bottom
        for (int i = 0; i < 20; i++)
            touch_way(3'd5, 4'd0);
        for (int k = 0; k <= NUM_WAY; k++)
        begin
            write_lock(data_t'((1 << k) - 1));
            query_victim(3'd5);
        end
        write_lock(32'h0);

        for (int i = 0; i < N_TOUCH; i++)
        begin
            set = set_idx_t'(rand32() % NUM_SETS);
            way = way_idx_t'(rand32() % NUM_WAY);
            touch_way(set, way);
            set = set_idx_t'(rand32() % NUM_SETS);
            query_victim(set);
        end

        for (int i = 0; i < N_LOCK; i++)
        begin
            set = set_idx_t'(rand32() % NUM_SETS);
            way = way_idx_t'(rand32() % NUM_WAY);
            touch_way(set, way);
            write_lock(rand32());
            query_victim(set);
            check_read(REG_LOCK, {16'd0, model_lock}, '1, "rdata of REG_LOCK");
        end
        write_lock(32'hffff_ffff);
        query_victim(set);
        write_lock(32'h0);

        value = rand32();
        axi_write(REG_QSET, value);
        check_read(REG_QSET, {29'd0, value[2:0]}, '1, "rdata of REG_QSET");

        // Writes to the victim register and to holes change nothing
        axi_write(8'h10, rand32());
        axi_write(REG_VICTIM, rand32());
        check_read(8'h10, 32'h0, '1, "rdata of offset 0x10");
        check_read(8'hFC, 32'h0, '1, "rdata of offset 0xFC");
        query_victim(value[2:0]);
    endtask

    initial
    begin
        logic timed_out;
        timed_out  = 1'b0;
        rst        = 1'b1;
        axil_req   = '0;
        model_lock = '0;
        model_age  = '{default: 0};
        fork
            run_stimulus();
            begin
                repeat (TIMEOUT_CYCLES) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any
        run_ended = 1'b1;
        if (timed_out)
        begin
            $display("Watchdog expired after %0d cycles, the test did not finish", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "Watchdog timeout");
        end
        else
        begin
            $display("Test completed successfully");
            $finish;
        end
    end

    // Bound assertion errors stop the run before the stimulus ends
    final
    begin
        if (!run_ended)
            $display("Test failed");
    end

endmodule

// ==== sim.f ====
rtl/repl_pkg.sv
rtl/axil_pkg.sv
rtl/max_age_tree.sv
rtl/age_table.sv
rtl/repl_axil_regs.sv
rtl/victim_select_top.sv
verification/victim_select_properties.sv
verification/tb_victim_select.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_victim_select
FILELIST := sim.f
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Test completed successfully
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
